// ==== hsid.f ====
+incdir+src
src/hsid_pkg.sv
src/hsid_elem_if.sv
src/hsid_fifo.sv
src/hsid_fsm.sv
src/hsid_mse.sv
src/hsid_mse_comp.sv
src/hsid.sv
tb/hsid_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the hsid testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
  -f hsid.f \
  --top-module hsid_tb \
  -Mdir obj_dir \
  && ./obj_dir/Vhsid_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== src/hsid.sv ====
`include "hsid_defines.svh"

module hsid (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        hsi_vctr_in_valid,  // Word strobe, only while ready
  input  logic [`HSID_WORD_WIDTH-1:0] hsi_vctr_in,        // Two packed samples
  input  logic [`HSID_LIB_ADDR:0]     library_size_in,    // Vectors in this run
  input  logic                        clear,              // Resets min and max results
  input  logic                        start,
  output logic [`HSID_LIB_ADDR-1:0]   mse_min_ref,
  output logic [`HSID_LIB_ADDR-1:0]   mse_max_ref,
  output logic [`HSID_WORD_WIDTH-1:0] mse_min_value,
  output logic [`HSID_WORD_WIDTH-1:0] mse_max_value,
  output logic                        done,
  output logic                        idle,
  output logic                        ready
);

  import hsid_pkg::*;

  hsid_state_t                 state;
  logic                        fifo_read;   // Common pop of both FIFO heads
  logic                        meas_full;
  logic                        meas_empty;
  logic                        ref_full;
  logic                        ref_empty;
  logic                        in_accept;
  logic                        meas_wr_en;
  logic                        ref_wr_en;
  logic [`HSID_WORD_WIDTH-1:0] meas_din;
  logic [`HSID_WORD_WIDTH-1:0] meas_dout;
  logic [`HSID_WORD_WIDTH-1:0] ref_dout;
  logic                        mse_valid;
  logic [`HSID_WORD_WIDTH-1:0] mse_value;
  logic [`HSID_LIB_ADDR-1:0]   mse_ref;
  logic                        comp_valid;

  hsid_elem_if u_elem ();

  // Input routing by controller state
  assign in_accept  = hsi_vctr_in_valid && ready;
  assign meas_wr_en = (state == READ_MEASURE && in_accept) ||
                      (state == COMPUTE_MSE && fifo_read && !u_elem.vctr_last);  // Recirculate
  assign meas_din   = (state == READ_MEASURE) ? hsi_vctr_in : meas_dout;
  assign ref_wr_en  = (state == COMPUTE_MSE) && in_accept;

  assign u_elem.element_a = meas_dout;
  assign u_elem.element_b = ref_dout;

  hsid_fifo #(.DEPTH(`HSID_ELEMENTS)) u_fifo_meas (
    .clk(clk), .rst_n(rst_n),
    .wr_en(meas_wr_en), .rd_en(fifo_read),
    .data_in(meas_din), .data_out(meas_dout),
    .full(meas_full), .empty(meas_empty)
  );

  hsid_fifo #(.DEPTH(`HSID_REF_DEPTH)) u_fifo_ref (
    .clk(clk), .rst_n(rst_n),
    .wr_en(ref_wr_en), .rd_en(fifo_read),
    .data_in(hsi_vctr_in), .data_out(ref_dout),
    .full(ref_full), .empty(ref_empty)
  );

  hsid_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .start(start), .library_size_in(library_size_in),
    .meas_full(meas_full), .meas_empty(meas_empty),
    .ref_full(ref_full), .ref_empty(ref_empty), .comp_valid(comp_valid),
    .state(state), .fifo_read(fifo_read), .elem(u_elem.src),
    .done(done), .idle(idle), .ready(ready)
  );

  hsid_mse u_mse (
    .clk(clk), .rst_n(rst_n), .elem(u_elem.dst),
    .mse_valid(mse_valid), .mse_value(mse_value), .mse_ref(mse_ref)
  );

  hsid_mse_comp u_mse_comp (
    .clk(clk), .rst_n(rst_n), .clear(clear),
    .mse_valid(mse_valid), .mse_value(mse_value), .mse_ref(mse_ref),
    .mse_min_value(mse_min_value), .mse_min_ref(mse_min_ref),
    .mse_max_value(mse_max_value), .mse_max_ref(mse_max_ref),
    .comp_valid(comp_valid)
  );

  a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
    hsi_vctr_in_valid |-> ready)
    else $error("hsid: input word dropped, offered without ready");

endmodule

// ==== src/hsid_defines.svh ====
`ifndef HSID_DEFINES_SVH
`define HSID_DEFINES_SVH

// Build-wide sizes of the identification block

`define HSID_WORD_WIDTH 32  // Bus word carrying two samples
`define HSID_DATA_WIDTH 16  // One unsigned sample
`define HSID_BANDS      16  // Samples per vector, power of two

`define HSID_ELEMENTS   (`HSID_BANDS / 2)  // Words per vector

`define HSID_LIB_SIZE   16  // Max library vectors per run
`define HSID_LIB_ADDR   4   // Library index width, log2 of lib size

`define HSID_REF_DEPTH  4   // Reference stream buffer entries

`endif

// ==== src/hsid_elem_if.sv ====
`include "hsid_defines.svh"

// Paired element stream from the FIFO heads into the error accumulator
interface hsid_elem_if;

  logic [`HSID_WORD_WIDTH-1:0] element_a;      // Measured word, FIFO head
  logic [`HSID_WORD_WIDTH-1:0] element_b;      // Reference word, FIFO head
  logic                        element_valid;  // Pair consumed this cycle
  logic                        element_start;  // First word of a vector
  logic                        element_last;   // Final word of a vector
  logic [`HSID_LIB_ADDR-1:0]   vctr_ref;       // Library index of the pair
  logic                        vctr_last;      // Index is the final library vector

  modport src (
    output element_valid, element_start, element_last, vctr_ref, vctr_last
  );

  modport dst (
    input element_a, element_b, element_valid, element_start, element_last, vctr_ref
  );

endinterface

// ==== src/hsid_fifo.sv ====
`include "hsid_defines.svh"

module hsid_fifo #(
  parameter int DEPTH = 4  // Number of word entries
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wr_en,
  input  logic                        rd_en,
  input  logic [`HSID_WORD_WIDTH-1:0] data_in,
  output logic [`HSID_WORD_WIDTH-1:0] data_out,
  output logic                        full,
  output logic                        empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`HSID_WORD_WIDTH-1:0] mem [DEPTH];  // Circular storage
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;       // Occupied entries
  logic                        do_wr;
  logic                        do_rd;

  // Wrap at DEPTH so non power of two depths also work
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_rd    = rd_en && !empty;
  assign do_wr    = wr_en && (!full || do_rd);  // Full only takes a write paired with a read
  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign data_out = mem[rd_ptr];  // Head visible without a read cycle

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or balanced read and write
      endcase
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> !empty)
    else $error("hsid_fifo: read while empty");

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en && full) |-> rd_en)
    else $error("hsid_fifo: write while full without a read");

endmodule

// ==== src/hsid_fsm.sv ====
`include "hsid_defines.svh"

module hsid_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [`HSID_LIB_ADDR:0]   library_size_in,
  input  logic                      meas_full,
  input  logic                      meas_empty,
  input  logic                      ref_full,
  input  logic                      ref_empty,
  input  logic                      comp_valid,
  output hsid_pkg::hsid_state_t     state,
  output logic                      fifo_read,
  hsid_elem_if.src                  elem,
  output logic                      done,
  output logic                      idle,
  output logic                      ready
);

  import hsid_pkg::*;

  localparam int ELEM_W = (`HSID_ELEMENTS > 1) ? $clog2(`HSID_ELEMENTS) : 1;
  localparam logic [ELEM_W-1:0]         ELEM_LAST = ELEM_W'(`HSID_ELEMENTS - 1);
  localparam logic [`HSID_LIB_ADDR:0]   LIB_MAX   = `HSID_LIB_SIZE;

  hsid_state_t               state_nxt;
  logic [`HSID_LIB_ADDR:0]   lib_size;   // Library size sampled at start
  logic [ELEM_W-1:0]         elem_cnt;   // Word position inside the current vector
  logic [`HSID_LIB_ADDR:0]   vctr_cnt;   // Library vector being read
  logic [`HSID_LIB_ADDR:0]   comp_cnt;   // Comparisons already finished
  logic                      elem_last;
  logic                      last_comp;

  // Both heads present means one measured/reference pair can be consumed
  assign fifo_read = (state == COMPUTE_MSE) && !meas_empty && !ref_empty;
  assign elem_last = (elem_cnt == ELEM_LAST);
  assign last_comp = comp_valid && (comp_cnt == lib_size - 1'b1);

  assign elem.element_valid = fifo_read;
  assign elem.element_start = fifo_read && (elem_cnt == '0);
  assign elem.element_last  = fifo_read && elem_last;
  assign elem.vctr_ref      = vctr_cnt[`HSID_LIB_ADDR-1:0];
  assign elem.vctr_last     = (vctr_cnt == lib_size - 1'b1);  // Stops measured recirculation

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:         if (start) state_nxt = READ_MEASURE;
      READ_MEASURE: if (meas_full) state_nxt = COMPUTE_MSE;  // Depth equals one vector
      COMPUTE_MSE:  if (last_comp) state_nxt = FINISH;
      FINISH:       state_nxt = IDLE;
      default:      state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lib_size <= '0;
      elem_cnt <= '0;
      vctr_cnt <= '0;
      comp_cnt <= '0;
    end else if (state == IDLE && start) begin
      lib_size <= library_size_in;  // Later start pulses are ignored
      elem_cnt <= '0;
      vctr_cnt <= '0;
      comp_cnt <= '0;
    end else begin
      if (fifo_read) begin
        if (elem_last) begin
          elem_cnt <= '0;
          vctr_cnt <= vctr_cnt + 1'b1;  // Next reference may enter before this error is out
        end else begin
          elem_cnt <= elem_cnt + 1'b1;
        end
      end
      if (comp_valid) comp_cnt <= comp_cnt + 1'b1;
    end
  end

  // Strobes and levels toward the caller
  assign done = (state == FINISH);
  assign idle = (state == IDLE);

  always_comb begin
    case (state)
      READ_MEASURE: ready = !meas_full;
      COMPUTE_MSE:  ready = !ref_full;
      default:      ready = 1'b0;
    endcase
  end

  a_lib_size: assert property (@(posedge clk) disable iff (!rst_n)
    (state != IDLE) |-> (lib_size != '0) && (lib_size <= LIB_MAX))
    else $error("hsid_fsm: library size %0d out of range", lib_size);

endmodule

// ==== src/hsid_mse.sv ====
`include "hsid_defines.svh"

module hsid_mse (
  input  logic                        clk,
  input  logic                        rst_n,
  hsid_elem_if.dst                    elem,
  output logic                        mse_valid,
  output logic [`HSID_WORD_WIDTH-1:0] mse_value,
  output logic [`HSID_LIB_ADDR-1:0]   mse_ref
);

  localparam int DW    = `HSID_DATA_WIDTH;
  localparam int SQ_W  = 2 * DW;                 // Square of one sample difference
  localparam int ACC_W = 40;                     // Per-vector sum of squares
  localparam int SHIFT = $clog2(`HSID_BANDS);    // Mean over bands

  logic [DW-1:0]                a0;
  logic [DW-1:0]                a1;
  logic [DW-1:0]                b0;
  logic [DW-1:0]                b1;
  logic [DW-1:0]                diff0;
  logic [DW-1:0]                diff1;
  logic [SQ_W-1:0]              sq0;       // Stage 1 low sample square
  logic [SQ_W-1:0]              sq1;       // Stage 1 high sample square
  logic                         s1_valid;
  logic                         s1_start;
  logic                         s1_last;
  logic [`HSID_LIB_ADDR-1:0]    s1_ref;
  logic [ACC_W-1:0]             acc;       // Running sum of the current vector
  logic [ACC_W-1:0]             acc_nxt;
  logic [ACC_W-1:0]             acc_shift;

  // Sample 0 sits in the low half of each word
  assign a0 = elem.element_a[DW-1:0];
  assign a1 = elem.element_a[2*DW-1:DW];
  assign b0 = elem.element_b[DW-1:0];
  assign b1 = elem.element_b[2*DW-1:DW];

  assign diff0 = (a0 > b0) ? a0 - b0 : b0 - a0;  // Unsigned absolute difference
  assign diff1 = (a1 > b1) ? a1 - b1 : b1 - a1;

  // Stage 1, squares with the stream tags carried alongside
  always_ff @(posedge clk) begin
    if (elem.element_valid) begin
      sq0      <= diff0 * diff0;
      sq1      <= diff1 * diff1;
      s1_start <= elem.element_start;
      s1_last  <= elem.element_last;
      s1_ref   <= elem.vctr_ref;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) s1_valid <= 1'b0;
    else        s1_valid <= elem.element_valid;
  end

  // Stage 2, restart on the first word of a vector
  assign acc_nxt   = (s1_start ? '0 : acc) + ACC_W'(sq0) + ACC_W'(sq1);
  assign acc_shift = acc_nxt >> SHIFT;

  always_ff @(posedge clk) begin
    if (s1_valid) acc <= acc_nxt;
    if (s1_valid && s1_last) begin
      mse_value <= acc_shift[`HSID_WORD_WIDTH-1:0];  // Truncated mean
      mse_ref   <= s1_ref;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) mse_valid <= 1'b0;
    else        mse_valid <= s1_valid && s1_last;  // Two cycles after the last read
  end

  a_tags_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (elem.element_start || elem.element_last) |-> elem.element_valid)
    else $error("hsid_mse: start or last tag without element_valid");

endmodule

// ==== src/hsid_mse_comp.sv ====
`include "hsid_defines.svh"

module hsid_mse_comp (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear,
  input  logic                        mse_valid,
  input  logic [`HSID_WORD_WIDTH-1:0] mse_value,
  input  logic [`HSID_LIB_ADDR-1:0]   mse_ref,
  output logic [`HSID_WORD_WIDTH-1:0] mse_min_value,
  output logic [`HSID_LIB_ADDR-1:0]   mse_min_ref,
  output logic [`HSID_WORD_WIDTH-1:0] mse_max_value,
  output logic [`HSID_LIB_ADDR-1:0]   mse_max_ref,
  output logic                        comp_valid
);

  logic new_min;
  logic new_max;

  // Strict compare keeps the earlier, lower index on a tie
  assign new_min = mse_value < mse_min_value;
  assign new_max = mse_value > mse_max_value;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      mse_min_value <= '1;  // Any first error becomes the minimum
      mse_min_ref   <= '0;
      mse_max_value <= '0;  // Any nonzero error becomes the maximum
      mse_max_ref   <= '0;
      comp_valid    <= 1'b0;
    end else begin
      comp_valid <= mse_valid;  // One cycle behind the accumulator
      if (mse_valid && new_min) begin
        mse_min_value <= mse_value;
        mse_min_ref   <= mse_ref;
      end
      if (mse_valid && new_max) begin
        mse_max_value <= mse_value;
        mse_max_ref   <= mse_ref;
      end
    end
  end

  a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(clear && mse_valid))
    else $error("hsid_mse_comp: clear during an arriving error");

endmodule

// ==== src/hsid_pkg.sv ====
package hsid_pkg;

  // Controller sequence for one identification run
  // Shared by the controller and the input write routing
  typedef enum logic [1:0] {
    IDLE         = 2'd0,  // Waiting for start
    READ_MEASURE = 2'd1,  // Capturing the measured pixel vector
    COMPUTE_MSE  = 2'd2,  // Streaming library vectors through the accumulator
    FINISH       = 2'd3   // Done strobe cycle
  } hsid_state_t;

endpackage

// ==== tb/hsid_tb.sv ====
`include "hsid_defines.svh"

module hsid_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ELEMS = `HSID_ELEMENTS;
  localparam int TIMEOUT_CYCLES = 6000;  // Five runs of up to 17 vectors, doubled

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        hsi_vctr_in_valid;
  logic [`HSID_WORD_WIDTH-1:0] hsi_vctr_in;
  logic [`HSID_LIB_ADDR:0]     library_size_in;
  logic                        clear;
  logic                        start;
  logic [`HSID_LIB_ADDR-1:0]   mse_min_ref;
  logic [`HSID_LIB_ADDR-1:0]   mse_max_ref;
  logic [`HSID_WORD_WIDTH-1:0] mse_min_value;
  logic [`HSID_WORD_WIDTH-1:0] mse_max_value;
  logic                        done;
  logic                        idle;
  logic                        ready;

  logic [31:0] lcg_state = 32'h00b4_6ad0;
  logic [31:0] meas [ELEMS];                       // Measured pixel words
  logic [31:0] lib  [`HSID_LIB_SIZE * ELEMS];      // Library words, vector major
  logic [31:0] exp_min_value;
  logic [31:0] exp_max_value;
  logic [3:0]  exp_min_ref;
  logic [3:0]  exp_max_ref;
  int          lib_n;
  int          comp_seen;
  int          err_count;
  int          cycle_count;
  int          tests_passed;
  int          tests_failed;

  hsid u_dut (
    .clk(clk), .rst_n(rst_n),
    .hsi_vctr_in_valid(hsi_vctr_in_valid), .hsi_vctr_in(hsi_vctr_in),
    .library_size_in(library_size_in), .clear(clear), .start(start),
    .mse_min_ref(mse_min_ref), .mse_max_ref(mse_max_ref),
    .mse_min_value(mse_min_value), .mse_max_value(mse_max_value),
    .done(done), .idle(idle), .ready(ready)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Mean squared error of library vector idx against the measurement
  function automatic logic [31:0] model_mse(input int idx);
    logic [63:0] sum;
    logic [63:0] d0;
    logic [63:0] d1;
    sum = '0;
    for (int k = 0; k < ELEMS; k++) begin
      d0 = (meas[k][15:0] > lib[idx*ELEMS+k][15:0]) ?
           meas[k][15:0] - lib[idx*ELEMS+k][15:0] : lib[idx*ELEMS+k][15:0] - meas[k][15:0];
      d1 = (meas[k][31:16] > lib[idx*ELEMS+k][31:16]) ?
           meas[k][31:16] - lib[idx*ELEMS+k][31:16] : lib[idx*ELEMS+k][31:16] - meas[k][31:16];
      sum = sum + d0 * d0 + d1 * d1;
    end
    return 32'(sum >> $clog2(`HSID_BANDS));
  endfunction

  // Strict compare in index order lets the lower index win ties
  task automatic build_expected();
    logic [31:0] v;
    exp_min_value = '1;
    exp_max_value = '0;
    exp_min_ref   = '0;
    exp_max_ref   = '0;
    for (int i = 0; i < lib_n; i++) begin
      v = model_mse(i);
      if (v < exp_min_value) begin
        exp_min_value = v;
        exp_min_ref   = 4'(i);
      end
      if (v > exp_max_value) begin
        exp_max_value = v;
        exp_max_ref   = 4'(i);
      end
    end
  endtask

  task automatic report_fail(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    err_count++;
  endtask

  // Wait for ready at the falling edge, then offer one word for one cycle
  task automatic send_word(input logic [31:0] w, input int gap);
    do @(negedge clk); while (!ready);
    @(posedge clk);
    hsi_vctr_in_valid <= 1'b1;
    hsi_vctr_in       <= w;
    @(posedge clk);
    hsi_vctr_in_valid <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // One full run; gaps are random when max_gap is nonzero
  task automatic run_identify(input string name, input int max_gap, input int restart_at);
    int errs_before;
    errs_before = err_count;
    build_expected();
    pulse_clear();
    @(posedge clk);
    library_size_in <= 5'(lib_n);
    pulse_start();
    for (int k = 0; k < ELEMS; k++) begin
      send_word(meas[k], (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0);
    end
    for (int i = 0; i < lib_n; i++) begin
      if (i == restart_at) pulse_start();  // Must be ignored mid-run
      for (int k = 0; k < ELEMS; k++) begin
        send_word(lib[i*ELEMS+k], (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0);
      end
    end
    do @(negedge clk); while (!done);
    repeat (3) @(posedge clk);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // Completed comparisons in the current run
  always @(posedge clk) begin
    if (start && idle) comp_seen <= 0;
    else if (u_dut.comp_valid) comp_seen <= comp_seen + 1;
  end

  a_results: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (mse_min_value == exp_min_value) && (mse_min_ref == exp_min_ref) &&
             (mse_max_value == exp_max_value) && (mse_max_ref == exp_max_ref))
    else report_fail($sformatf("result min %0d@%0d max %0d@%0d, expected %0d@%0d %0d@%0d",
      mse_min_value, mse_min_ref, mse_max_value, mse_max_ref,
      exp_min_value, exp_min_ref, exp_max_value, exp_max_ref));

  a_full_run: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (comp_seen == lib_n) && $past(u_dut.comp_valid))
    else report_fail("done without every comparison or not right after the last one");

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> idle && !done && !ready)
    else report_fail("wrong idle, done or ready level after reset");

  a_clear_values: assert property (@(posedge clk) disable iff (!rst_n)
    $past(clear) |-> (mse_min_value == '1) && (mse_max_value == '0) &&
                     (mse_min_ref == '0) && (mse_max_ref == '0))
    else report_fail("results not cleared");

  a_hold_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (idle && !clear) |=> $stable(mse_min_value) && $stable(mse_max_value) &&
                         $stable(mse_min_ref) && $stable(mse_max_ref))
    else report_fail("results changed while idle");

  a_start_leaves_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (idle && start) |=> !idle)
    else report_fail("idle still high after start");

  a_busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
    (!idle && !done) |=> !idle)
    else report_fail("idle returned before done");

  a_done_then_idle: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> idle && !done)
    else report_fail("done not a single pulse followed by idle");

  a_offer_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
    hsi_vctr_in_valid |-> ready)
    else report_fail("word offered while ready was low");

  // Stop a stuck run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    int errs_before;
    rst_n             <= 1'b0;
    hsi_vctr_in_valid <= 1'b0;
    hsi_vctr_in       <= '0;
    library_size_in   <= '0;
    clear             <= 1'b0;
    start             <= 1'b0;
    err_count    = 0;
    cycle_count  = 0;
    comp_seen    = 0;
    lib_n        = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Reset levels and clear
    errs_before = err_count;
    repeat (2) @(posedge clk);
    pulse_clear();
    repeat (5) @(posedge clk);
    if (err_count == errs_before) tests_passed++;
    else tests_failed++;
    $display("Test reset_clear: %s", (err_count == errs_before) ? "pass" : "errors");

    // Directed library where vector 2 equals the measurement
    for (int k = 0; k < ELEMS; k++) meas[k] = {16'(1000 + 20 * k), 16'(500 + 10 * k)};
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < ELEMS; k++) begin
        lib[i*ELEMS+k] = meas[k] + {16'(i * 7), 16'(i * 3)} - {16'(14), 16'(6)};
      end
    end
    lib_n = 4;
    run_identify("directed", 0, -1);

    // Full random library with duplicates at both extremes
    for (int k = 0; k < ELEMS; k++) meas[k] = next_rand();
    for (int j = 0; j < `HSID_LIB_SIZE * ELEMS; j++) lib[j] = next_rand();
    for (int k = 0; k < ELEMS; k++) begin
      lib[3*ELEMS+k]  = meas[k];  // Zero error
      lib[7*ELEMS+k]  = {meas[k][31] ? 16'h0000 : 16'hffff,
                         meas[k][15] ? 16'h0000 : 16'hffff};  // Farthest value per band
      lib[11*ELEMS+k] = lib[3*ELEMS+k];
      lib[13*ELEMS+k] = lib[7*ELEMS+k];
    end
    lib_n = `HSID_LIB_SIZE;
    run_identify("random_ties", 0, -1);

    // Random gaps between words
    for (int j = 0; j < `HSID_LIB_SIZE * ELEMS; j++) lib[j] = next_rand() & 32'h0fff_0fff;
    lib_n = int'(next_rand() % `HSID_LIB_SIZE) + 1;
    run_identify("backpressure", 3, -1);

    // Extra start pulse in the middle of a run
    lib_n = 6;
    run_identify("control_strobes", 1, 3);

    $display("Tests passed %0d, failed %0d, check errors %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
